// ==== pkg_tpu.sv ====
// Sizes for the scratch buffer subsystem. NUM_ENTRY must equal 2**WIDTH_ENTRY, BURST_LEN under 8
package pkg_tpu;

	////////////////////////////////////////////////////////////////////////////
	// Buffer addressing

	typedef logic [31:0]	address_t;			// Region base, one word

	////////////////////////////////////////////////////////////////////////////
	// Lanes

	localparam int		NUM_LANE	= 3;		// Lanes per side

	typedef logic [1:0]		lane_no_t;			// Granted lane number

	////////////////////////////////////////////////////////////////////////////
	// Region table

	localparam int		NUM_ENTRY	= 8;		// Regions held
	localparam int		WIDTH_ENTRY	= 3;		// Index width

	typedef logic [WIDTH_ENTRY-1:0]	entry_no_t;	// Table index

	////////////////////////////////////////////////////////////////////////////
	// Transfers
	//
	// Every transfer is the same number of ready beats. The beat counter
	// wraps at BURST_LEN - 1, so count_t only needs to hold that value.

	localparam int		BURST_LEN	= 4;		// Beats per transfer

	typedef logic [2:0]		count_t;			// Beat counter

endpackage

// ==== entry_encoder.sv ====
// Lowest set bit wins when several entries hit; entry reads zero when found is low
`timescale 1ns/1ps

module entry_encoder (
	input	logic	[pkg_tpu::NUM_ENTRY-1:0]	hit,		// Per-entry match
	output	pkg_tpu::entry_no_t				entry,		// Index of lowest match
	output	logic							found		// Any entry matched
);

	// Scan from the top so the lowest hit is the last one written
	always_comb begin
		entry = '0;
		for (int i = pkg_tpu::NUM_ENTRY - 1; i >= 0; i--) begin
			if (hit[i]) begin
				entry = pkg_tpu::entry_no_t'(i);
			end
		end
	end

	assign found = |hit;								// Hit anywhere

endmodule

// ==== lane_arbiter.sv ====
// Requests and bases must stay stable until the lane sees xfer_end; one grant at a time
`timescale 1ns/1ps

module lane_arbiter (
	input	logic							clock,
	input	logic							reset,
	input	logic	[pkg_tpu::NUM_LANE-1:0]	req,			// Lane requests
	input	pkg_tpu::address_t				base_1,			// Base of lane 1
	input	pkg_tpu::address_t				base_2,			// Base of lane 2
	input	pkg_tpu::address_t				base_3,			// Base of lane 3
	input	logic							xfer_end,		// Last beat of transfer
	output	logic	[pkg_tpu::NUM_LANE-1:0]	grant,			// One-hot grant
	output	logic							grant_vld,		// Grant active
	output	pkg_tpu::lane_no_t				grant_no,		// Granted lane
	output	pkg_tpu::address_t				grant_base		// Base of granted lane
);

	logic	[pkg_tpu::NUM_LANE-1:0]	eligible;
	logic	[pkg_tpu::NUM_LANE-1:0]	pick_oh;
	logic							pick_vld;
	logic							issue;
	pkg_tpu::lane_no_t				pick_no;
	pkg_tpu::lane_no_t				cand;
	pkg_tpu::address_t				pick_base;

	////////////////////////////////////////////////////////////////////////////
	// Selection

	// The ending lane still holds its request during its end cycle
	assign eligible	= grant_vld ? (req & ~grant) : req;
	assign issue	= ~grant_vld | xfer_end;				// Grant slot free next edge

	// grant_no doubles as the rotating pointer. Walk from the farthest
	// candidate to the nearest so the lane right after it wins.
	always_comb begin
		pick_vld	= 1'b0;
		pick_no		= grant_no;
		cand		= grant_no;
		for (int k = pkg_tpu::NUM_LANE; k >= 1; k--) begin
			cand = pkg_tpu::lane_no_t'((int'(grant_no) + k) % pkg_tpu::NUM_LANE);
			if (eligible[cand]) begin
				pick_vld	= 1'b1;
				pick_no		= cand;
			end
		end
		pick_oh				= '0;
		pick_oh[pick_no]	= pick_vld;
	end

	always_comb begin
		case (pick_no)
			2'd0:		pick_base = base_1;
			2'd1:		pick_base = base_2;
			default:	pick_base = base_3;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Grant registers

	always_ff @(posedge clock) begin
		if (reset) begin
			grant		<= '0;
			grant_vld	<= 1'b0;
			grant_no	<= pkg_tpu::lane_no_t'(pkg_tpu::NUM_LANE - 1);	// Lane 1 first
		end
		else if (issue) begin
			grant		<= pick_oh;
			grant_vld	<= pick_vld;
			if (pick_vld) begin
				grant_no	<= pick_no;							// Keep last served lane
			end
		end
	end

	always_ff @(posedge clock) begin
		if (issue && pick_vld) begin
			grant_base	<= pick_base;						// Travels with grant
		end
	end

	a_grant_onehot: assert property (@(posedge clock) disable iff (reset)
		grant_vld |-> $onehot(grant));

endmodule

// ==== pub_domain_man.sv ====
// New regions go only into the write-pointer slot, so a full table frees in allocation order
`timescale 1ns/1ps

module pub_domain_man (
	input	logic					clock,
	input	logic					reset,
	input	logic					stall,				// Freeze both sides
	input	logic					st_grant_vld,		// Store grant active
	input	pkg_tpu::address_t		st_grant_base,		// Store region base
	input	logic					st_end,				// Store last beat
	input	logic					ld_grant_vld,		// Load grant active
	input	pkg_tpu::address_t		ld_grant_base,		// Load region base
	input	logic					ld_end,				// Load last beat
	output	logic					st_ready,			// Store beat allowed
	output	logic					ld_ready,			// Load beat allowed
	output	logic					st_set_config,		// Store grant hit table
	output	logic					ld_set_config		// Load grant hit table
);

	logic	[pkg_tpu::NUM_ENTRY-1:0]	valid;
	logic	[pkg_tpu::NUM_ENTRY-1:0]	filled;
	pkg_tpu::address_t					tab_base	[pkg_tpu::NUM_ENTRY];
	pkg_tpu::entry_no_t					wptr;

	logic	[pkg_tpu::NUM_ENTRY-1:0]	st_hit;
	logic	[pkg_tpu::NUM_ENTRY-1:0]	ld_hit;
	pkg_tpu::entry_no_t					st_entry;
	pkg_tpu::entry_no_t					ld_entry;
	logic								st_found;
	logic								ld_found;

	logic								st_vld_q;
	logic								ld_vld_q;
	logic								st_end_q;
	logic								ld_end_q;
	logic								st_start;
	logic								ld_start;
	logic								st_alloc;
	logic								st_upd;
	logic								ld_upd;
	pkg_tpu::entry_no_t					st_entry_q;
	pkg_tpu::entry_no_t					ld_entry_q;

	////////////////////////////////////////////////////////////////////////////
	// Lookup

	always_comb begin
		for (int i = 0; i < pkg_tpu::NUM_ENTRY; i++) begin
			st_hit[i] = valid[i] & (tab_base[i] == st_grant_base);
			ld_hit[i] = valid[i] & (tab_base[i] == ld_grant_base);
		end
	end

	entry_encoder st_enc_inst (
		.hit	(st_hit),
		.entry	(st_entry),
		.found	(st_found)
	);

	entry_encoder ld_enc_inst (
		.hit	(ld_hit),
		.entry	(ld_entry),
		.found	(ld_found)
	);

	////////////////////////////////////////////////////////////////////////////
	// Grant start and ready decision

	// A back-to-back grant keeps grant_vld high, so the old end marks the start
	assign st_start	= st_grant_vld & (~st_vld_q | st_end_q);
	assign ld_start	= ld_grant_vld & (~ld_vld_q | ld_end_q);

	assign st_alloc	= st_grant_vld & ~st_found & ~valid[wptr] & ~stall;	// Miss, slot free
	assign st_ready	= st_alloc | (st_grant_vld & st_found & ~filled[st_entry] & ~stall);
	assign ld_ready	= ld_grant_vld & ld_found & filled[ld_entry] & ~stall;

	assign st_upd	= st_end & ~stall;
	assign ld_upd	= ld_end & ~stall;

	assign st_set_config	= st_start & st_found;
	assign ld_set_config	= ld_start & ld_found;

	always_ff @(posedge clock) begin
		if (reset) begin
			st_vld_q	<= 1'b0;
			ld_vld_q	<= 1'b0;
			st_end_q	<= 1'b0;
			ld_end_q	<= 1'b0;
		end
		else begin
			st_vld_q	<= st_grant_vld;
			ld_vld_q	<= ld_grant_vld;
			st_end_q	<= st_end;
			ld_end_q	<= ld_end;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Entry latches
	//
	// Also refreshed on each hit beat, so a load that was granted before its
	// region existed still knows which entry to clear at its end.

	always_ff @(posedge clock) begin
		if (reset) begin
			st_entry_q	<= '0;
			ld_entry_q	<= '0;
		end
		else begin
			if (st_alloc) begin
				st_entry_q	<= wptr;							// Fresh region
			end
			else if (st_found && (st_start || st_ready)) begin
				st_entry_q	<= st_entry;
			end
			if (ld_found && (ld_start || ld_ready)) begin
				ld_entry_q	<= ld_entry;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Table state

	always_ff @(posedge clock) begin
		if (reset) begin
			valid	<= '0;
			filled	<= '0;
			wptr	<= '0;
		end
		else begin
			if (st_alloc) begin
				valid[wptr]	<= 1'b1;
				wptr		<= wptr + 1'b1;						// Next slot in turn
			end
			if (st_upd) begin
				filled[st_entry_q]	<= 1'b1;					// Region ready to drain
			end
			if (ld_upd) begin
				valid[ld_entry_q]	<= 1'b0;					// Region free again
				filled[ld_entry_q]	<= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (st_alloc) begin
			tab_base[wptr]	<= st_grant_base;
		end
	end

	a_filled_valid: assert property (@(posedge clock) disable iff (reset)
		(filled & ~valid) == '0);

	a_st_end_ready: assert property (@(posedge clock) disable iff (reset)
		st_end |-> st_ready);

	a_ld_end_ready: assert property (@(posedge clock) disable iff (reset)
		ld_end |-> ld_ready);

endmodule

// ==== transfer_sequencer.sv ====
// Fixed-length transfers only; the count carries over gaps in ready and never restarts early
`timescale 1ns/1ps

module transfer_sequencer (
	input	logic	clock,
	input	logic	reset,
	input	logic	ready,								// Beat allowed this cycle
	output	logic	xfer_end							// Last beat of transfer
);

	localparam pkg_tpu::count_t LAST_BEAT = pkg_tpu::count_t'(pkg_tpu::BURST_LEN - 1);

	pkg_tpu::count_t	count;

	////////////////////////////////////////////////////////////////////////////
	// Beat counter

	// End falls on the same cycle as the final beat
	assign xfer_end = ready & (count == LAST_BEAT);

	always_ff @(posedge clock) begin
		if (reset) begin
			count	<= '0;
		end
		else if (ready) begin
			if (count == LAST_BEAT) begin
				count	<= '0;								// Ready for next transfer
			end
			else begin
				count	<= count + 1'b1;
			end
		end
	end

	a_count_range: assert property (@(posedge clock) disable iff (reset)
		count <= LAST_BEAT);

endmodule

// ==== domain_top.sv ====
// Lanes hold request and base until their end pulse; stall freezes every transfer in flight
`timescale 1ns/1ps

module domain_top (
	input	logic							clock,
	input	logic							reset,
	input	logic							stall,			// Freeze both sides
	input	logic	[pkg_tpu::NUM_LANE-1:0]	st_req,			// Store lane requests
	input	logic	[pkg_tpu::NUM_LANE-1:0]	ld_req,			// Load lane requests
	input	pkg_tpu::address_t				st_base_1,
	input	pkg_tpu::address_t				st_base_2,
	input	pkg_tpu::address_t				st_base_3,
	input	pkg_tpu::address_t				ld_base_1,
	input	pkg_tpu::address_t				ld_base_2,
	input	pkg_tpu::address_t				ld_base_3,
	output	logic	[pkg_tpu::NUM_LANE-1:0]	st_ready_lane,	// Per-lane store ready
	output	logic	[pkg_tpu::NUM_LANE-1:0]	ld_ready_lane,	// Per-lane load ready
	output	logic	[pkg_tpu::NUM_LANE-1:0]	st_end_lane,	// Per-lane store end
	output	logic	[pkg_tpu::NUM_LANE-1:0]	ld_end_lane,	// Per-lane load end
	output	logic							st_set_config,
	output	logic							ld_set_config
);

	logic	[pkg_tpu::NUM_LANE-1:0]	st_grant;
	logic	[pkg_tpu::NUM_LANE-1:0]	ld_grant;
	logic							st_grant_vld;
	logic							ld_grant_vld;
	pkg_tpu::address_t				st_grant_base;
	pkg_tpu::address_t				ld_grant_base;
	logic							st_ready;
	logic							ld_ready;
	logic							st_end;
	logic							ld_end;

	////////////////////////////////////////////////////////////////////////////
	// Store side

	lane_arbiter st_arb_inst (
		.clock		(clock),
		.reset		(reset),
		.req		(st_req),
		.base_1		(st_base_1),
		.base_2		(st_base_2),
		.base_3		(st_base_3),
		.xfer_end	(st_end),
		.grant		(st_grant),
		.grant_vld	(st_grant_vld),
		.grant_no	(),										// Pointer kept inside
		.grant_base	(st_grant_base)
	);

	transfer_sequencer st_seq_inst (
		.clock		(clock),
		.reset		(reset),
		.ready		(st_ready),
		.xfer_end	(st_end)
	);

	////////////////////////////////////////////////////////////////////////////
	// Load side

	lane_arbiter ld_arb_inst (
		.clock		(clock),
		.reset		(reset),
		.req		(ld_req),
		.base_1		(ld_base_1),
		.base_2		(ld_base_2),
		.base_3		(ld_base_3),
		.xfer_end	(ld_end),
		.grant		(ld_grant),
		.grant_vld	(ld_grant_vld),
		.grant_no	(),
		.grant_base	(ld_grant_base)
	);

	transfer_sequencer ld_seq_inst (
		.clock		(clock),
		.reset		(reset),
		.ready		(ld_ready),
		.xfer_end	(ld_end)
	);

	////////////////////////////////////////////////////////////////////////////
	// Region table

	pub_domain_man domain_man_inst (
		.clock			(clock),
		.reset			(reset),
		.stall			(stall),
		.st_grant_vld	(st_grant_vld),
		.st_grant_base	(st_grant_base),
		.st_end			(st_end),
		.ld_grant_vld	(ld_grant_vld),
		.ld_grant_base	(ld_grant_base),
		.ld_end			(ld_end),
		.st_ready		(st_ready),
		.ld_ready		(ld_ready),
		.st_set_config	(st_set_config),
		.ld_set_config	(ld_set_config)
	);

	// Steer side signals to the granted lane
	assign st_ready_lane	= st_grant & {pkg_tpu::NUM_LANE{st_ready}};
	assign ld_ready_lane	= ld_grant & {pkg_tpu::NUM_LANE{ld_ready}};
	assign st_end_lane		= st_grant & {pkg_tpu::NUM_LANE{st_end}};
	assign ld_end_lane		= ld_grant & {pkg_tpu::NUM_LANE{ld_end}};

endmodule

// ==== tb_domain_top.sv ====
// Stimulus rows run in order from reset; the table model tracks the same write-pointer slots
`timescale 1ns/1ps

module tb_domain_top;

	localparam int	NUM_ROWS	= 13;
	localparam int	SEED		= 24267;
	localparam int	LIMIT		= NUM_ROWS * (pkg_tpu::BURST_LEN + 20) + 10;
	localparam int	K_ONE		= 0;						// Single transfer
	localparam int	K_BLOCK		= 1;						// Blocked until partner ends
	localparam int	K_RR		= 2;						// All store lanes at once
	localparam int	K_STALL		= 3;						// Transfer under stall gaps

	logic							clock;
	logic							reset;
	logic							stall;
	logic	[pkg_tpu::NUM_LANE-1:0]	st_req;
	logic	[pkg_tpu::NUM_LANE-1:0]	ld_req;
	pkg_tpu::address_t				st_base_1, st_base_2, st_base_3;
	pkg_tpu::address_t				ld_base_1, ld_base_2, ld_base_3;
	logic	[pkg_tpu::NUM_LANE-1:0]	st_ready_lane, ld_ready_lane;
	logic	[pkg_tpu::NUM_LANE-1:0]	st_end_lane, ld_end_lane;
	logic							st_set_config, ld_set_config;

	int					errors		= 0;
	int					cycles		= 0;
	int					st_cfg_cnt	= 0;
	int					ld_cfg_cnt	= 0;
	pkg_tpu::address_t	bases		[16];
	int					r_kind		[NUM_ROWS];
	int					r_side		[NUM_ROWS];			// 0 store, 1 load
	int					r_lane		[NUM_ROWS];
	int					r_b			[NUM_ROWS];
	int					r_lane2		[NUM_ROWS];
	int					r_b2		[NUM_ROWS];

	// Reference region table
	logic				m_valid		[pkg_tpu::NUM_ENTRY];
	logic				m_filled	[pkg_tpu::NUM_ENTRY];
	pkg_tpu::address_t	m_base		[pkg_tpu::NUM_ENTRY];
	int					m_wptr;
	int					last_st;

	domain_top domain_top_inst (.*);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("Run stopped because the transfers did not finish within the cycle limit");
			$display("tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %0h expected %0h", name, got, exp);
		end
	endtask

	task automatic check_lanes(string name, logic [pkg_tpu::NUM_LANE-1:0] got,
		logic [pkg_tpu::NUM_LANE-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %0h expected %0h", name, got, exp);
		end
	endtask

	task automatic check_addr(string name, pkg_tpu::address_t got, pkg_tpu::address_t exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %0h expected %0h", name, got, exp);
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp) begin
			errors++;
			$display("Fail %s: got %0h expected %0h", name, got, exp);
		end
	endtask

	// Outputs settle mid-cycle
	always @(negedge clock) begin
		if (reset || stall) begin
			check_lanes("st_ready_lane", st_ready_lane, '0);
			check_lanes("ld_ready_lane", ld_ready_lane, '0);
		end
		if (reset) begin
			check_lanes("st_end_lane", st_end_lane, '0);
			check_lanes("ld_end_lane", ld_end_lane, '0);
			check_bit("st_set_config", st_set_config, 1'b0);
			check_bit("ld_set_config", ld_set_config, 1'b0);
		end
		else begin
			if (st_set_config) st_cfg_cnt++;
			if (ld_set_config) ld_cfg_cnt++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic int find_hit(pkg_tpu::address_t b);
		for (int i = 0; i < pkg_tpu::NUM_ENTRY; i++) begin
			if (m_valid[i] && m_base[i] == b) return i;
		end
		return -1;
	endfunction

	function automatic logic may_proceed(int side, pkg_tpu::address_t b);
		int e;
		e = find_hit(b);
		if (side == 1) return (e >= 0) && m_filled[e];
		if (e >= 0) return !m_filled[e];
		return !m_valid[m_wptr];								// Miss needs free slot
	endfunction

	task automatic model_end(int side, int lane, pkg_tpu::address_t b);
		int e;
		e = find_hit(b);
		if (side == 1) begin
			m_valid[e]	= 1'b0;
			m_filled[e]	= 1'b0;
		end
		else begin
			if (e < 0) begin
				e			= m_wptr;
				m_valid[e]	= 1'b1;
				m_base[e]	= b;
				m_wptr		= (m_wptr + 1) % pkg_tpu::NUM_ENTRY;
			end
			m_filled[e]	= 1'b1;
			last_st		= lane;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Lane driving

	task automatic drive_lane(int side, int lane, pkg_tpu::address_t b, logic on);
		if (side == 0) begin
			st_req[lane] = on;
			case (lane)
				0:			st_base_1 = b;
				1:			st_base_2 = b;
				default:	st_base_3 = b;
			endcase
		end
		else begin
			ld_req[lane] = on;
			case (lane)
				0:			ld_base_1 = b;
				1:			ld_base_2 = b;
				default:	ld_base_3 = b;
			endcase
		end
	endtask

	task automatic run_xfer(int side, int lane, pkg_tpu::address_t b,
		output int first_rdy, output int end_cyc);
		int		beats;
		logic	rdy;
		logic	fin;
		beats		= 0;
		first_rdy	= -1;
		fin			= 1'b0;
		@(posedge clock);
		#2;
		drive_lane(side, lane, b, 1'b1);
		while (!fin) begin
			@(negedge clock);
			rdy	= (side == 0) ? st_ready_lane[lane] : ld_ready_lane[lane];
			fin	= (side == 0) ? st_end_lane[lane] : ld_end_lane[lane];
			if (rdy) begin
				if (first_rdy < 0) begin
					first_rdy = cycles;
					check_addr("grant_base", (side == 0) ? domain_top_inst.st_grant_base
						: domain_top_inst.ld_grant_base, b);
				end
				beats++;
			end
			check_bit("end on ready beat", !fin || rdy, 1'b1);
		end
		end_cyc = cycles;
		check_count("ready beats", beats, pkg_tpu::BURST_LEN);
		model_end(side, lane, b);
		@(posedge clock);
		#2;
		drive_lane(side, lane, b, 1'b0);						// Released after end
	endtask

	task automatic set_row(int n, int k, int side, int lane, int b, int lane2, int b2);
		r_kind[n]	= k;
		r_side[n]	= side;
		r_lane[n]	= lane;
		r_b[n]		= b;
		r_lane2[n]	= lane2;
		r_b2[n]		= b2;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		logic	[31:0]	rnd;
		int				fr		[3];
		int				ec		[3];
		int				cfg0;
		int				hit;
		int				ln;
		rnd			= $urandom(SEED);
		reset		= 1'b1;
		stall		= 1'b0;
		st_req		= '0;
		ld_req		= '0;
		st_base_1	= '0;
		st_base_2	= '0;
		st_base_3	= '0;
		ld_base_1	= '0;
		ld_base_2	= '0;
		ld_base_3	= '0;
		for (int i = 0; i < 16; i++) begin
			rnd			= $urandom();
			bases[i]	= {rnd[31:4], 4'(i)};					// Distinct by low nibble
		end
		for (int i = 0; i < pkg_tpu::NUM_ENTRY; i++) begin
			m_valid[i]	= 1'b0;
			m_filled[i]	= 1'b0;
			m_base[i]	= '0;
		end
		m_wptr	= 0;
		last_st	= pkg_tpu::NUM_LANE - 1;
		set_row(0, K_ONE, 0, 0, 0, 0, 0);
		set_row(1, K_ONE, 1, 1, 0, 0, 0);						// Drains region of row 0
		set_row(2, K_BLOCK, 1, 2, 1, 1, 1);						// Load waits for store
		set_row(3, K_ONE, 0, 2, 1, 0, 0);						// Base 1 filled again
		set_row(4, K_BLOCK, 0, 0, 1, 0, 1);						// Store waits for drain
		set_row(5, K_RR, 0, 0, 2, 0, 0);
		set_row(6, K_STALL, 0, 1, 5, 0, 0);
		set_row(7, K_STALL, 1, 0, 1, 0, 0);
		set_row(8, K_ONE, 0, 2, 6, 0, 0);
		set_row(9, K_ONE, 0, 0, 7, 0, 0);
		set_row(10, K_ONE, 0, 1, 8, 0, 0);
		set_row(11, K_ONE, 0, 2, 9, 0, 0);						// Table now full
		set_row(12, K_BLOCK, 0, 2, 10, 1, 3);					// Free the oldest slot
		repeat (10) @(posedge clock);
		#2;
		reset = 1'b0;

		for (int n = 0; n < NUM_ROWS; n++) begin
			hit		= (find_hit(bases[r_b[n]]) >= 0) ? 1 : 0;
			cfg0	= (r_side[n] == 0) ? st_cfg_cnt : ld_cfg_cnt;
			case (r_kind[n])
				K_ONE, K_STALL: begin
					check_bit("model ready", may_proceed(r_side[n], bases[r_b[n]]), 1'b1);
					fork
						run_xfer(r_side[n], r_lane[n], bases[r_b[n]], fr[0], ec[0]);
						begin
							if (r_kind[n] == K_STALL) begin
								repeat (3) begin
									repeat (1 + $urandom() % 3) @(posedge clock);
									#2;
									stall = 1'b1;
									repeat (1 + $urandom() % 4) @(posedge clock);
									#2;
									stall = 1'b0;
								end
							end
						end
					join
				end
				K_BLOCK: begin
					check_bit("model blocked", may_proceed(r_side[n], bases[r_b[n]]), 1'b0);
					fork
						run_xfer(r_side[n], r_lane[n], bases[r_b[n]], fr[0], ec[0]);
						begin
							repeat (6) @(posedge clock);
							run_xfer(1 - r_side[n], r_lane2[n], bases[r_b2[n]], fr[1], ec[1]);
						end
					join
					check_bit("blocked lane waits for partner end", fr[0] > ec[1], 1'b1);
				end
				default: begin
					ln = last_st;
					fork
						run_xfer(0, 0, bases[r_b[n]], fr[0], ec[0]);
						run_xfer(0, 1, bases[r_b[n] + 1], fr[1], ec[1]);
						run_xfer(0, 2, bases[r_b[n] + 2], fr[2], ec[2]);
					join
					check_bit("round-robin order", ec[(ln + 1) % 3] < ec[(ln + 2) % 3], 1'b1);
					check_bit("round-robin order", ec[(ln + 2) % 3] < ec[ln], 1'b1);
				end
			endcase
			// One pulse only when the row's base already sat in the table
			check_count("set_config pulses",
				((r_side[n] == 0) ? st_cfg_cnt : ld_cfg_cnt) - cfg0, hit);
		end

		repeat (2) @(posedge clock);
		$display("Errors counted: %0d", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end
		else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
pkg_tpu.sv
entry_encoder.sv
lane_arbiter.sv
pub_domain_man.sv
transfer_sequencer.sv
domain_top.sv
tb_domain_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_domain_top -o sim_domain_top

out=$(./obj_dir/sim_domain_top)
echo "$out"

if echo "$out" | grep -q "all tests passed"; then
	exit 0
else
	exit 1
fi
